//--- build.f
fp_pkg.sv
fp_lzd.sv
fp_unpack.sv
fp_ctrl.sv
fp_mul_lane.sv
fp_add_lane.sv
fp_round.sv
fpu_top.sv
tb_fpu.sv

//--- run.sh
#!/bin/sh
# builds the FPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_fpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- tb_fpu.sv
// testbench for the pipelined single-precision FPU
// directed and random add, sub and mul checked against an integer-exact model
module tb_fpu;

  localparam int n_rand     = 300;
  localparam int n_directed = 20;
  localparam int n_tests    = n_rand + n_directed;
  localparam int timeout    = (n_tests + 50) * 8;

  localparam logic [2:0] op_add = 3'b001;
  localparam logic [2:0] op_sub = 3'b010;
  localparam logic [2:0] op_mul = 3'b100;

  localparam logic [2:0] rne = 3'b000;
  localparam logic [2:0] rtz = 3'b001;
  localparam logic [2:0] rdn = 3'b010;
  localparam logic [2:0] rup = 3'b011;

  // flags are {overflow, underflow, inexact}
  localparam logic [2:0] f_none = 3'b000;
  localparam logic [2:0] f_inx  = 3'b001;
  localparam logic [2:0] f_unf  = 3'b011;
  localparam logic [2:0] f_ovf  = 3'b101;

  localparam logic [31:0] pos_inf   = 32'h7f800000;
  localparam logic [31:0] nan_word  = 32'h7fc00000;
  localparam logic [31:0] max_fin   = 32'h7f7fffff;
  // 2^-30 and 2^-100
  localparam logic [31:0] tiny_30   = 32'h30800000;
  localparam logic [31:0] tiny_100  = 32'h0d800000;

  typedef struct packed {
    logic        is_mul;
    logic [31:0] res;
    logic [2:0]  flags;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        op_valid;
  logic [2:0]  op;
  logic [31:0] a;
  logic [31:0] b;
  logic [2:0]  frm;
  logic [31:0] fadd_result;
  logic [2:0]  fadd_flags;
  logic [31:0] fmul_result;
  logic [2:0]  fmul_flags;
  logic        done;

  expect_t pending[$];
  int      errors = 0;
  int      checks = 0;

  fpu_top dut (
    .clk         (clk),
    .rst         (rst),
    .op_valid    (op_valid),
    .op          (op),
    .a           (a),
    .b           (b),
    .frm         (frm),
    .fadd_result (fadd_result),
    .fadd_flags  (fadd_flags),
    .fmul_result (fmul_result),
    .fmul_flags  (fmul_flags),
    .done        (done)
  );

  always #4 clk = ~clk;

  // exact for magnitudes below 2^24
  function automatic logic [31:0] int_to_float(input longint v);
    logic   sign;
    longint mag;
    int     p;
    int     i;
    sign = (v < 0);
    mag  = sign ? -v : v;
    p    = 0;
    if (mag == 0) return 32'h0;
    for (i = 0; i < 24; i++) begin
      if (mag[i]) p = i;
    end
    return {sign, 8'(127 + p), 23'(mag << (23 - p))};
  endfunction

  // exact zero is negative only when rounding down
  function automatic logic [31:0] sum_to_float(input longint r, input logic [2:0] mode);
    if (r == 0) return (mode == rdn) ? 32'h80000000 : 32'h0;
    return int_to_float(r);
  endfunction

  function automatic longint random_operand(input int bits);
    longint mag;
    mag = longint'($urandom % ((32'd1 << bits) - 32'd1)) + 1;
    return ($urandom % 2) ? -mag : mag;
  endfunction

  task automatic issue(input logic [2:0] op_bits, input logic [31:0] x, input logic [31:0] y,
                       input logic [2:0] mode, input logic [31:0] want,
                       input logic [2:0] want_flags);
    expect_t e;
    @(posedge clk);
    #1;
    op_valid = 1'b1;
    op       = op_bits;
    a        = x;
    b        = y;
    frm      = mode;
    e.is_mul = op_bits[2];
    e.res    = want;
    e.flags  = want_flags;
    pending.push_back(e);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      op_valid = 1'b0;
      op       = 3'b000;
    end
  endtask

  task automatic check_lane(input string lane, input logic [31:0] got,
                            input logic [2:0] got_flags, input logic [31:0] want,
                            input logic [2:0] want_flags);
    checks++;
    assert (got === want && got_flags === want_flags) else begin
      errors++;
      $display("Error at %0t: %s result %h flags %b, expected %h flags %b",
               $time, lane, got, got_flags, want, want_flags);
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    expect_t e;
    if (!rst) begin
      if (done && pending.size() == 0) begin
        errors++;
        $display("Error at %0t: done pulse with no operation outstanding", $time);
      end else if (done) begin
        e = pending.pop_front();
        if (e.is_mul) begin
          check_lane("fmul", fmul_result, fmul_flags, e.res, e.flags);
          check_lane("idle fadd", fadd_result, fadd_flags, 32'h0, f_none);
        end else begin
          check_lane("fadd", fadd_result, fadd_flags, e.res, e.flags);
          check_lane("idle fmul", fmul_result, fmul_flags, 32'h0, f_none);
        end
      end else begin
        check_lane("idle fadd", fadd_result, fadd_flags, 32'h0, f_none);
        check_lane("idle fmul", fmul_result, fmul_flags, 32'h0, f_none);
      end
    end
  end

  latency_check: assert property (@(posedge clk) disable iff (rst)
    done == $past(op_valid, 3)) else begin
    errors++;
    $display("done pulse at %0t does not sit 3 cycles after a strobe", $time);
  end

  initial begin
    #(timeout);
    $display("timeout: the run did not finish within %0d time units", timeout);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int          seed;
    int          n;
    int          kind;
    logic [2:0]  mode;
    longint      x;
    longint      y;
    seed     = $urandom(32'h88b7);
    rst      = 1'b1;
    op_valid = 1'b0;
    op       = 3'b000;
    a        = 32'h0;
    b        = 32'h0;
    frm      = rne;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);

    // special values
    issue(op_add, 32'h7f800001, int_to_float(1), rne, nan_word, f_none);
    issue(op_mul, pos_inf, 32'h0, rne, nan_word, f_none);
    issue(op_sub, pos_inf, pos_inf, rne, nan_word, f_none);
    issue(op_mul, pos_inf, int_to_float(-2), rne, 32'hff800000, f_none);
    // subnormals count as zero
    issue(op_mul, 32'h00000001, int_to_float(2), rne, 32'h0, f_none);
    issue(op_add, 32'h00400000, int_to_float(1), rne, int_to_float(1), f_none);

    // only round-up moves 1.0 + 2^-30 off 1.0
    for (n = 0; n < 4; n++) begin
      mode = 3'(n);
      issue(op_add, int_to_float(1), tiny_30, mode,
            (mode == rup) ? 32'h3f800001 : 32'h3f800000, f_inx);
    end
    issue(op_add, int_to_float(-1), {1'b1, tiny_30[30:0]}, rdn, 32'hbf800001, f_inx);

    issue(op_mul, max_fin, int_to_float(2), rne, pos_inf, f_ovf);
    issue(op_mul, max_fin, int_to_float(2), rtz, max_fin, f_ovf);
    issue(op_mul, max_fin, int_to_float(2), 3'b100, pos_inf, f_ovf);
    issue(op_mul, tiny_100, tiny_100, rne, 32'h0, f_unf);

    // x - x in every mode, plus one unsupported code
    for (n = 0; n < 5; n++) begin
      mode = (n == 4) ? 3'b110 : 3'(n);
      x    = random_operand(20);
      issue(op_sub, int_to_float(x), int_to_float(x), mode, sum_to_float(0, mode), f_none);
    end
    idle(2);

    // mixed back-to-back traffic
    for (n = 0; n < n_rand; n++) begin
      kind = $urandom % 3;
      mode = 3'($urandom % 4);
      if (kind == 2) begin
        x = random_operand(11);
        y = random_operand(11);
        issue(op_mul, int_to_float(x), int_to_float(y), mode, int_to_float(x * y), f_none);
      end else begin
        x = random_operand(20);
        y = random_operand(20);
        issue((kind == 1) ? op_sub : op_add, int_to_float(x), int_to_float(y), mode,
              sum_to_float((kind == 1) ? x - y : x + y, mode), f_none);
      end
    end
    idle(1);

    while (pending.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- fpu_top.sv
// pipelined single-precision FPU with add/sub and multiply lanes
// three-cycle latency, one operation per cycle, idle lane outputs zero
module fpu_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           op_valid,
  input  fp_pkg::op_t    op,
  input  fp_pkg::float_t a,
  input  fp_pkg::float_t b,
  input  fp_pkg::rm_t    frm,
  output fp_pkg::float_t fadd_result,
  output fp_pkg::flags_t fadd_flags,
  output fp_pkg::float_t fmul_result,
  output fp_pkg::flags_t fmul_flags,
  output logic           done
);
  import fp_pkg::*;

  logic             sign_a;
  logic             sign_b;
  logic [exp_w-1:0] exp_a;
  logic [exp_w-1:0] exp_b;
  sig_t             sig_a;
  sig_t             sig_b;
  logic             zero_a;
  logic             zero_b;
  logic             inf_a;
  logic             inf_b;
  logic             nan_a;
  logic             nan_b;

  logic             sub_s1;
  rm_t              rm_s1;
  logic             add_s2;
  logic             mul_s2;
  rm_t              rm_s2;

  pre_round_t       pre_add;
  pre_round_t       pre_mul;

  fp_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .op_valid (op_valid),
    .op       (op),
    .frm      (frm),
    .sub_s1   (sub_s1),
    .rm_s1    (rm_s1),
    .add_s2   (add_s2),
    .mul_s2   (mul_s2),
    .rm_s2    (rm_s2),
    .done     (done)
  );

  fp_unpack u_unpack (
    .clk    (clk),
    .rst    (rst),
    .a      (a),
    .b      (b),
    .sign_a (sign_a),
    .sign_b (sign_b),
    .exp_a  (exp_a),
    .exp_b  (exp_b),
    .sig_a  (sig_a),
    .sig_b  (sig_b),
    .zero_a (zero_a),
    .zero_b (zero_b),
    .inf_a  (inf_a),
    .inf_b  (inf_b),
    .nan_a  (nan_a),
    .nan_b  (nan_b)
  );

  fp_mul_lane u_mul_lane (
    .clk    (clk),
    .rst    (rst),
    .sign_a (sign_a),
    .sign_b (sign_b),
    .exp_a  (exp_a),
    .exp_b  (exp_b),
    .sig_a  (sig_a),
    .sig_b  (sig_b),
    .zero_a (zero_a),
    .zero_b (zero_b),
    .inf_a  (inf_a),
    .inf_b  (inf_b),
    .nan_a  (nan_a),
    .nan_b  (nan_b),
    .pre    (pre_mul)
  );

  fp_add_lane u_add_lane (
    .clk    (clk),
    .rst    (rst),
    .sub_s1 (sub_s1),
    .rm     (rm_s1),
    .sign_a (sign_a),
    .sign_b (sign_b),
    .exp_a  (exp_a),
    .exp_b  (exp_b),
    .sig_a  (sig_a),
    .sig_b  (sig_b),
    .zero_a (zero_a),
    .zero_b (zero_b),
    .inf_a  (inf_a),
    .inf_b  (inf_b),
    .nan_a  (nan_a),
    .nan_b  (nan_b),
    .pre    (pre_add)
  );

  // sub shares the add lane outputs
  fp_round round_add (
    .clk    (clk),
    .rst    (rst),
    .pre    (pre_add),
    .rm     (rm_s2),
    .active (add_s2),
    .result (fadd_result),
    .flags  (fadd_flags)
  );

  fp_round round_mul (
    .clk    (clk),
    .rst    (rst),
    .pre    (pre_mul),
    .rm     (rm_s2),
    .active (mul_s2),
    .result (fmul_result),
    .flags  (fmul_flags)
  );

endmodule

//--- fp_round.sv
// rounding and output stage for one lane
// applies the rounding mode, handles overflow and flush-to-zero, and builds flags
module fp_round (
  input  logic               clk,
  input  logic               rst,
  input  fp_pkg::pre_round_t pre,
  input  fp_pkg::rm_t        rm,
  input  logic               active,
  output fp_pkg::float_t     result,
  output fp_pkg::flags_t     flags
);
  import fp_pkg::*;

  localparam logic signed [exp_w+1:0] exp_max = 2**exp_w - 1;

  logic                    inexact;
  logic                    inc;
  logic                    to_inf;
  logic [man_w+1:0]        rounded;
  sig_t                    sig_r;
  logic signed [exp_w+1:0] exp_r;
  float_t                  res_d;
  flags_t                  flags_d;

  always_comb begin
    inexact = pre.guard | pre.round | pre.sticky;
    case (rm)
      rm_rtz:  inc = 1'b0;
      rm_rdn:  inc = pre.sign & inexact;
      rm_rup:  inc = ~pre.sign & inexact;
      default: inc = pre.guard & (pre.round | pre.sticky | pre.sig[0]);
    endcase

    rounded = {1'b0, pre.sig} + (man_w+2)'(inc);
    if (rounded[man_w+1]) begin
      sig_r = rounded[man_w+1:1];
      exp_r = pre.exp + (exp_w+2)'(1);
    end else begin
      sig_r = rounded[man_w:0];
      exp_r = pre.exp;
    end

    // modes that round toward zero for this sign saturate at max finite
    to_inf = !((rm == rm_rtz) || (rm == rm_rdn && !pre.sign) || (rm == rm_rup && pre.sign));

    flags_d = '0;
    case (pre.special)
      sp_nan:  res_d = canon_nan;
      sp_inf:  res_d = {pre.sign, {exp_w{1'b1}}, {man_w{1'b0}}};
      sp_zero: res_d = {pre.sign, {(exp_w+man_w){1'b0}}};
      default: begin
        if (exp_r >= exp_max) begin
          flags_d.overflow = 1'b1;
          flags_d.inexact  = 1'b1;
          res_d = to_inf ? {pre.sign, {exp_w{1'b1}}, {man_w{1'b0}}} :
                           {pre.sign, {(exp_w-1){1'b1}}, 1'b0, {man_w{1'b1}}};
        end else if (exp_r[exp_w+1] || exp_r == '0) begin
          // below the normal range, flush
          flags_d.underflow = 1'b1;
          flags_d.inexact   = 1'b1;
          res_d = {pre.sign, {(exp_w+man_w){1'b0}}};
        end else begin
          flags_d.inexact = inexact;
          res_d = {pre.sign, exp_r[exp_w-1:0], sig_r[man_w-1:0]};
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || !active) begin
      result <= '0;
      flags  <= '0;
    end else begin
      result <= res_d;
      flags  <= flags_d;
    end
  end

  // either lane must hand over a normalized significand for a finite result
  assert property (@(posedge clk) disable iff (rst)
    active && pre.special == sp_none |-> pre.sig[man_w]);

endmodule

//--- fp_add_lane.sv
// add/subtract lane, stage 2
// operand swap, sticky alignment, add or subtract and leading-zero normalization
module fp_add_lane (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     sub_s1,
  input  fp_pkg::rm_t              rm,
  input  logic                     sign_a,
  input  logic                     sign_b,
  input  logic [fp_pkg::exp_w-1:0] exp_a,
  input  logic [fp_pkg::exp_w-1:0] exp_b,
  input  fp_pkg::sig_t             sig_a,
  input  fp_pkg::sig_t             sig_b,
  input  logic                     zero_a,
  input  logic                     zero_b,
  input  logic                     inf_a,
  input  logic                     inf_b,
  input  logic                     nan_a,
  input  logic                     nan_b,
  output fp_pkg::pre_round_t       pre
);
  import fp_pkg::*;

  // significand plus guard, round and sticky
  localparam int ext_w = man_w + 4;

  logic                    sign_b_eff;
  logic                    eff_sub;
  logic                    a_big;
  logic                    sign_big;
  logic [exp_w-1:0]        exp_big;
  logic [exp_w-1:0]        diff;
  sig_t                    sig_big;
  sig_t                    sig_small;
  logic [2*man_w+3:0]      shifted;
  logic [ext_w-1:0]        aligned;
  logic [ext_w:0]          sum;
  logic [4:0]              lz;
  logic [ext_w-1:0]        norm;
  logic signed [exp_w+1:0] exp_ext;
  pre_round_t              pre_d;

  assign sign_b_eff = sign_b ^ sub_s1;
  assign eff_sub    = sign_a ^ sign_b_eff;
  assign a_big      = {exp_a, sig_a} >= {exp_b, sig_b};

  assign sign_big  = a_big ? sign_a : sign_b_eff;
  assign exp_big   = a_big ? exp_a : exp_b;
  assign sig_big   = a_big ? sig_a : sig_b;
  assign sig_small = a_big ? sig_b : sig_a;
  assign diff      = a_big ? (exp_a - exp_b) : (exp_b - exp_a);

  // bits shifted past the round position collapse into sticky
  assign shifted = {sig_small, (man_w+3)'(0)} >> diff;
  assign aligned = (diff <= exp_w'(man_w + 3)) ?
                   {shifted[2*man_w+3 -: man_w+3], |shifted[man_w:0]} :
                   {(ext_w-1)'(0), |sig_small};

  assign sum = eff_sub ? ({1'b0, sig_big, 3'b000} - {1'b0, aligned}) :
                         ({1'b0, sig_big, 3'b000} + {1'b0, aligned});

  fp_lzd u_lzd (
    .sum   (sum[ext_w-1:0]),
    .count (lz)
  );

  assign norm    = sum[ext_w-1:0] << lz;
  assign exp_ext = $signed({2'b00, exp_big});

  always_comb begin
    pre_d.sign = sign_big;
    if (sum[ext_w]) begin
      // carry out of the add
      pre_d.exp    = exp_ext + (exp_w+2)'(1);
      pre_d.sig    = sum[ext_w -: man_w+1];
      pre_d.guard  = sum[3];
      pre_d.round  = sum[2];
      pre_d.sticky = |sum[1:0];
    end else begin
      pre_d.exp    = exp_ext - (exp_w+2)'(lz);
      pre_d.sig    = norm[ext_w-1 -: man_w+1];
      pre_d.guard  = norm[2];
      pre_d.round  = norm[1];
      pre_d.sticky = norm[0];
    end

    if (nan_a || nan_b || (inf_a && inf_b && eff_sub)) begin
      pre_d.special = sp_nan;
    end else if (inf_a || inf_b) begin
      pre_d.special = sp_inf;
      pre_d.sign    = inf_a ? sign_a : sign_b_eff;
    end else if (sum == '0) begin
      // exact cancellation is -0 only when rounding down
      pre_d.special = sp_zero;
      pre_d.sign    = eff_sub ? (rm == rm_rdn) : (sign_a & zero_a & zero_b);
    end else begin
      pre_d.special = sp_none;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // cleared register holds a zero result
      pre         <= '0;
      pre.special <= sp_zero;
    end else begin
      pre <= pre_d;
    end
  end

  // lzd count must leave the hidden bit set on any finite nonzero sum
  assert property (@(posedge clk) disable iff (rst)
    pre.special == sp_none |-> pre.sig[man_w]);

endmodule

//--- fp_mul_lane.sv
// multiply lane, stage 2
// exponent sum, significand product and one-step normalization
module fp_mul_lane (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     sign_a,
  input  logic                     sign_b,
  input  logic [fp_pkg::exp_w-1:0] exp_a,
  input  logic [fp_pkg::exp_w-1:0] exp_b,
  input  fp_pkg::sig_t             sig_a,
  input  fp_pkg::sig_t             sig_b,
  input  logic                     zero_a,
  input  logic                     zero_b,
  input  logic                     inf_a,
  input  logic                     inf_b,
  input  logic                     nan_a,
  input  logic                     nan_b,
  output fp_pkg::pre_round_t       pre
);
  import fp_pkg::*;

  logic [2*man_w+1:0]      prod;
  logic signed [exp_w+1:0] exp_sum;
  pre_round_t              pre_d;

  assign prod    = sig_a * sig_b;
  assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - (exp_w+2)'(bias);

  always_comb begin
    pre_d.sign = sign_a ^ sign_b;
    // product lies in [1,4), so at most one right shift
    if (prod[2*man_w+1]) begin
      pre_d.exp    = exp_sum + (exp_w+2)'(1);
      pre_d.sig    = prod[2*man_w+1 -: man_w+1];
      pre_d.guard  = prod[man_w];
      pre_d.round  = prod[man_w-1];
      pre_d.sticky = |prod[man_w-2:0];
    end else begin
      pre_d.exp    = exp_sum;
      pre_d.sig    = prod[2*man_w -: man_w+1];
      pre_d.guard  = prod[man_w-1];
      pre_d.round  = prod[man_w-2];
      pre_d.sticky = |prod[man_w-3:0];
    end

    if (nan_a || nan_b || (inf_a && zero_b) || (zero_a && inf_b)) begin
      pre_d.special = sp_nan;
    end else if (inf_a || inf_b) begin
      pre_d.special = sp_inf;
    end else if (zero_a || zero_b) begin
      pre_d.special = sp_zero;
    end else begin
      pre_d.special = sp_none;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pre <= '0;
    end else begin
      pre <= pre_d;
    end
  end

endmodule

//--- fp_ctrl.sv
// pipeline control for the FPU
// decodes the opcode and carries valid, lane select and rounding mode to done
module fp_ctrl (
  input  logic        clk,
  input  logic        rst,
  input  logic        op_valid,
  input  fp_pkg::op_t op,
  input  fp_pkg::rm_t frm,
  output logic        sub_s1,
  output fp_pkg::rm_t rm_s1,
  output logic        add_s2,
  output logic        mul_s2,
  output fp_pkg::rm_t rm_s2,
  output logic        done
);
  import fp_pkg::*;

  // one bit per stage, the last one is done
  logic [pipe_depth-1:0] valid_q;
  op_t                   op_s1;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      op_s1   <= '0;
      rm_s1   <= rm_rne;
      add_s2  <= 1'b0;
      mul_s2  <= 1'b0;
      rm_s2   <= rm_rne;
    end else begin
      valid_q <= {valid_q[pipe_depth-2:0], op_valid};
      op_s1   <= op_valid ? op : '0;
      // unsupported modes fall back to nearest-even
      rm_s1   <= frm[2] ? rm_rne : frm;
      add_s2  <= valid_q[0] & (op_s1.add | op_s1.sub);
      mul_s2  <= valid_q[0] & op_s1.mul;
      rm_s2   <= rm_s1;
    end
  end

  assign sub_s1 = valid_q[0] & op_s1.sub;
  assign done   = valid_q[pipe_depth-1];

  // a strobe selects exactly one lane
  assert property (@(posedge clk) disable iff (rst) op_valid |-> $onehot(op));

endmodule

//--- fp_unpack.sv
// operand unpack stage
// registers a and b, restores the hidden bit and classifies special values
module fp_unpack (
  input  logic                     clk,
  input  logic                     rst,
  input  fp_pkg::float_t           a,
  input  fp_pkg::float_t           b,
  output logic                     sign_a,
  output logic                     sign_b,
  output logic [fp_pkg::exp_w-1:0] exp_a,
  output logic [fp_pkg::exp_w-1:0] exp_b,
  output fp_pkg::sig_t             sig_a,
  output fp_pkg::sig_t             sig_b,
  output logic                     zero_a,
  output logic                     zero_b,
  output logic                     inf_a,
  output logic                     inf_b,
  output logic                     nan_a,
  output logic                     nan_b
);
  import fp_pkg::*;

  // subnormals lose their fraction here
  function automatic sig_t restore(float_t f);
    return (f.exp == '0) ? '0 : {1'b1, f.man};
  endfunction

  function automatic logic is_inf(float_t f);
    return (&f.exp) && (f.man == '0);
  endfunction

  function automatic logic is_nan(float_t f);
    return (&f.exp) && (f.man != '0);
  endfunction

  always_ff @(posedge clk) begin
    sign_a <= a.sign;
    sign_b <= b.sign;
    exp_a  <= a.exp;
    exp_b  <= b.exp;
    sig_a  <= restore(a);
    sig_b  <= restore(b);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      zero_a <= 1'b0;
      zero_b <= 1'b0;
      inf_a  <= 1'b0;
      inf_b  <= 1'b0;
      nan_a  <= 1'b0;
      nan_b  <= 1'b0;
    end else begin
      zero_a <= (a.exp == '0);
      zero_b <= (b.exp == '0);
      inf_a  <= is_inf(a);
      inf_b  <= is_inf(b);
      nan_a  <= is_nan(a);
      nan_b  <= is_nan(b);
    end
  end

endmodule

//--- fp_lzd.sv
// leading-zero counter for the add lane sum
// binary tree search over 27 bits padded with ones to 32
module fp_lzd (
  input  logic [26:0] sum,
  output logic [4:0]  count
);

  logic [31:0] x0;
  logic [31:0] x1;
  logic [31:0] x2;
  logic [31:0] x3;
  logic        top;

  // ones in the pad stop the count at 27 for a zero sum
  assign x0 = {sum, 5'b11111};

  assign count[4] = ~|x0[31:16];
  assign x1       = count[4] ? {x0[15:0], 16'h0} : x0;

  assign count[3] = ~|x1[31:24];
  assign x2       = count[3] ? {x1[23:0], 8'h0} : x1;

  assign count[2] = ~|x2[31:28];
  assign x3       = count[2] ? {x2[27:0], 4'h0} : x2;

  assign count[1] = ~|x3[31:30];
  assign top      = count[1] ? x3[29] : x3[31];

  assign count[0] = ~top;

endmodule

//--- fp_pkg.sv
// shared definitions for the single-precision FPU
// format constants, opcode and rounding types, and the pre-round lane result
package fp_pkg;

  localparam int exp_w      = 8;
  localparam int man_w      = 23;
  localparam int bias       = 127;
  localparam int pipe_depth = 3;

  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [man_w-1:0] man;
  } float_t;

  // significand with the hidden bit on top
  typedef logic [man_w:0] sig_t;

  // one-hot, add in bit 0
  typedef struct packed {
    logic mul;
    logic sub;
    logic add;
  } op_t;

  // codes above 3'b011 are treated as nearest-even
  typedef logic [2:0] rm_t;
  localparam rm_t rm_rne = 3'b000;
  localparam rm_t rm_rtz = 3'b001;
  localparam rm_t rm_rdn = 3'b010;
  localparam rm_t rm_rup = 3'b011;

  typedef struct packed {
    logic overflow;
    logic underflow;
    logic inexact;
  } flags_t;

  typedef enum logic [1:0] {
    sp_none,
    sp_zero,
    sp_inf,
    sp_nan
  } special_t;

  // lane result ahead of rounding, exponent still biased but signed
  typedef struct packed {
    logic                    sign;
    logic signed [exp_w+1:0] exp;
    sig_t                    sig;
    logic                    guard;
    logic                    round;
    logic                    sticky;
    special_t                special;
  } pre_round_t;

  localparam float_t canon_nan = 32'h7fc00000;

endpackage
